//--- Bender.yml
package:
  name: mem_system

sources:
  - files:
      - common/cache_pkg.sv
  - files:
      - cache/cache_tag_array.sv
      - cache/cache_data_array.sv
      - cache/cache_fill_fsm.sv
  - files:
      - hdl/main_memory.sv
      - hdl/mem_system.sv
  - target: test
    files:
      - bench/mem_system_props.sv
      - bench/mem_system_tb.sv

//--- bench/mem_system_props.sv
`timescale 1ns/100ps
module mem_system_props import cache_pkg::*; (
  input logic clk,
  input logic rst,
  input logic stall,              // also the memory request level
  input logic write_data_array,
  input logic write_tag_array,
  input logic mem_valid
);

  // one word costs an accept cycle plus MEM_LATENCY, a line is 8 of those
  localparam int FILL_BOUND = BLOCK_WORDS * (MEM_LATENCY + 1) + 2;

  // data words written in the current fill, counted apart from the fsm
  logic [3:0] words_written;

  always_ff @(posedge clk) begin
    if (rst || !stall)
      words_written <= '0;                       // restarts with every fill
    else if (write_data_array)
      words_written <= words_written + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // fill protocol
  //////////////////////////////////////////////////////////////////////
  // tag and valid go in together with the eighth data word of the fill
  tag_with_data: assert property (@(posedge clk) disable iff (rst)
    write_tag_array |-> write_data_array && (words_written == BLOCK_WORDS - 1))
    else $error("tag array written without the last data array write");

  // stall is mem_read at the top level, no response without a request
  valid_needs_read: assert property (@(posedge clk) disable iff (rst)
    mem_valid |-> stall)
    else $error("memory valid pulse while no read was requested");

  // a fill always finishes
  fill_bounded: assert property (@(posedge clk) disable iff (rst)
    $rose(stall) |-> ##[1:FILL_BOUND] !stall)
    else $error("stall held longer than one line fill allows");

  // data writes only happen inside a fill
  write_in_fill: assert property (@(posedge clk) disable iff (rst)
    write_data_array |-> stall)
    else $error("data array written outside a fill");

endmodule

bind mem_system mem_system_props props_inst (
  .clk              (clk),
  .rst              (rst),
  .stall            (stall),
  .write_data_array (write_data_array),
  .write_tag_array  (write_tag_array),
  .mem_valid        (mem_valid)
);

//--- bench/mem_system_tb.sv
`timescale 1ns/100ps
module mem_system_tb import cache_pkg::*; ();

  localparam int EXPECT_MISS  = 0;
  localparam int EXPECT_HIT   = 1;
  localparam int FILL_TIMEOUT = 2 * BLOCK_WORDS * (MEM_LATENCY + 1) + 16;
  localparam int RAND_READS   = 300;

  logic  clk;
  logic  rst;
  logic  rd;
  addr_t addr;
  word_t rd_data;
  logic  hit;
  logic  stall;

  int          errors       = 0;
  int          reads_issued = 0;
  int          reads_done   = 0;   // counted by the compare process
  int          rand_hits    = 0;
  int          rand_misses  = 0;
  string       cur_test     = "reset";
  logic [31:0] lcg_state    = 32'h530b;

  // shadow of the tag array, kept from completed reads
  logic        shadow_valid [NUM_SETS];
  logic [7:0]  shadow_tag   [NUM_SETS];

  mem_system mem_system_inst (
    .clk     (clk),
    .rst     (rst),
    .rd      (rd),
    .addr    (addr),
    .rd_data (rd_data),
    .hit     (hit),
    .stall   (stall)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;   // 10 ns period

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  // rom word is the word address xor the key
  function automatic word_t exp_word(input addr_t a);
    return {1'b0, a[15:1]} ^ MEM_KEY;
  endfunction

  function automatic logic [3:0] line_index(input addr_t a);
    return a[7:4];
  endfunction

  function automatic logic [7:0] line_tag(input addr_t a);
    return a[15:8];
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // compare on every completed read, values taken before the edge updates
  always @(posedge clk) begin
    if (!rst && rd && hit && !stall) begin
      reads_done++;
      if (rd_data !== exp_word(addr)) begin
        errors++;
        $display("Error %s: addr %h expected %h actual %h",
                 cur_test, addr, exp_word(addr), rd_data);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic report_and_finish();
    $display("errors %0d, reads completed %0d of %0d", errors, reads_done, reads_issued);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  // one processor read, returns whether the first cycle hit
  task automatic read_word(input addr_t a, input int expect_hit, output logic was_hit);
    int   waited;
    logic saw_stall;
    waited    = 0;
    saw_stall = 1'b0;
    @(negedge clk);
    rd   = 1'b1;
    addr = a;
    reads_issued++;
    #1;                                  // settle the combinational outputs
    was_hit = hit;
    if (stall !== 1'b0) begin
      errors++;
      $display("Error %s: addr %h stall at read start expected 0 actual %b",
               cur_test, a, stall);
    end
    if (was_hit !== expect_hit[0]) begin
      errors++;
      $display("Error %s: addr %h hit expected %0d actual %b",
               cur_test, a, expect_hit, was_hit);
    end
    if (was_hit !== 1'b1) begin
      // miss, wait for the fill to end and the line to hit
      do begin
        @(negedge clk);
        #1;
        waited++;
        if (stall === 1'b1)
          saw_stall = 1'b1;
        if (waited > FILL_TIMEOUT) begin
          errors++;
          $display("Timeout in %s: stall did not fall for addr %h", cur_test, a);
          report_and_finish();
        end
      end while (!(hit === 1'b1 && stall === 1'b0));
      if (!saw_stall) begin
        errors++;
        $display("%s: miss on addr %h completed without raising stall", cur_test, a);
      end
    end
    shadow_valid[line_index(a)] = 1'b1;  // line is resident now
    shadow_tag[line_index(a)]   = line_tag(a);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    rd  = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_SETS; i++)
      shadow_valid[i] = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic  h;
    addr_t a;
    addr_t b;
    int    expect_hit;
    rst  = 1'b1;
    rd   = 1'b0;
    addr = '0;
    for (int i = 0; i < NUM_SETS; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i]   = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // cold miss
    cur_test = "cold_miss";
    read_word(16'h1234, EXPECT_MISS, h);

    // every word of the line just filled
    cur_test = "line_hits";
    for (int w = 0; w < BLOCK_WORDS; w++)
      read_word({12'h123, 3'(w), 1'b0}, EXPECT_HIT, h);

    // same index 6, tags 55 and 99 keep evicting each other
    cur_test = "conflict";
    a = 16'h5560;
    b = 16'h9964;
    for (int i = 0; i < 3; i++) begin
      read_word(a, EXPECT_MISS, h);
      read_word(a + 16'd2, EXPECT_HIT, h);  // re-read right after the fill
      read_word(b, EXPECT_MISS, h);
      read_word(b + 16'd6, EXPECT_HIT, h);
    end

    // random traffic over 4 tags, shadow predicts hit or miss
    cur_test = "random";
    for (int n = 0; n < RAND_READS; n++) begin
      lcg_state = lcg_next(lcg_state);
      a = (lcg_state[31:16] & 16'h03ff) | 16'ha400;   // tags a4..a7
      if (shadow_valid[line_index(a)] && shadow_tag[line_index(a)] == line_tag(a))
        expect_hit = EXPECT_HIT;
      else
        expect_hit = EXPECT_MISS;
      read_word(a, expect_hit, h);
      if (h === 1'b1)
        rand_hits++;
      else
        rand_misses++;
    end
    if (rand_hits == 0 || rand_misses == 0) begin
      errors++;
      $display("random traffic did not mix hits and misses (%0d hits, %0d misses)",
               rand_hits, rand_misses);
    end

    // reset between reads drops every line
    cur_test = "mid_reset";
    a = 16'h2e48;                        // tag 2e never touched before
    read_word(a, EXPECT_MISS, h);
    read_word(a, EXPECT_HIT, h);
    apply_reset();
    read_word(a, EXPECT_MISS, h);
    read_word(a, EXPECT_HIT, h);

    @(negedge clk);
    rd = 1'b0;
    @(negedge clk);
    if (reads_done != reads_issued) begin
      errors++;
      $display("Error final: completed reads expected %0d actual %0d",
               reads_issued, reads_done);
    end
    report_and_finish();
  end

endmodule

//--- cache/cache_data_array.sv
`timescale 1ns/100ps
module cache_data_array import cache_pkg::*; (
  input  logic  clk,
  input  logic  write_data_array,  // one word of a line fill
  input  addr_t addr,              // processor read address
  input  addr_t fill_addr,         // memory address of the returning word
  input  word_t fill_data,         // word from main memory
  output word_t rd_data            // combinational read
);

  //////////////////////////////////////////////////////////////////////
  // 16 sets x 8 words, flattened as {index, offset}
  //////////////////////////////////////////////////////////////////////
  word_t mem [DATA_WORDS];

  logic [INDEX_W+OFFSET_W-1:0] rd_ptr;   // processor side
  logic [INDEX_W+OFFSET_W-1:0] wr_ptr;   // fill side

  assign rd_ptr = {get_index(addr), get_offset(addr)};
  assign wr_ptr = {get_index(fill_addr), get_offset(fill_addr)};

  // read straight out of the array, same cycle as the tag compare
  assign rd_data = mem[rd_ptr];

  // single write port, lands at the next edge
  always_ff @(posedge clk) begin
    if (write_data_array)
      mem[wr_ptr] <= fill_data;
  end

endmodule

//--- cache/cache_fill_fsm.sv
`timescale 1ns/100ps
module cache_fill_fsm import cache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  miss_detected,     // tag compare failed on a live read
  input  logic  mem_valid,         // one pulse per word coming back
  input  addr_t miss_addr,         // held by the processor while stalled
  output logic  busy,              // stall to the cpu, request level to memory
  output logic  write_data_array,  // one write per returning word
  output logic  write_tag_array,   // tag and valid, with the last word
  output addr_t mem_addr           // word currently requested
);

  //////////////////////////////////////////////////////////////////////
  // word counter
  //////////////////////////////////////////////////////////////////////
  // 3 bits cover the 8 words of a line, wraps to 0 after the last one
  offset_t cnt;
  logic    done;      // last word of the line is arriving

  always_ff @(posedge clk) begin
    if (rst)
      cnt <= '0;
    else if (mem_valid)
      cnt <= cnt + 1'b1;    // 7 -> 0 on the final word
  end

  // done only in the cycle of the eighth valid pulse
  assign done = mem_valid && (cnt == offset_t'(BLOCK_WORDS - 1));

  //////////////////////////////////////////////////////////////////////
  // fill state machine
  //////////////////////////////////////////////////////////////////////
  fill_state_t state, nxt_state;

  always_ff @(posedge clk) begin
    if (rst)
      state <= fill_idle;
    else
      state <= nxt_state;
  end

  // busy comes from the state register only. miss_detected already looks
  // at stall, so a combinational term here would close a loop through the
  // tag array. stall therefore rises in the cycle after the miss is seen
  always_comb begin
    nxt_state        = state;   // hold by default
    busy             = 1'b0;
    write_data_array = 1'b0;
    write_tag_array  = 1'b0;
    case (state)
      fill_idle: begin
        if (miss_detected)
          nxt_state = fill_wait;
      end
      fill_wait: begin
        busy             = 1'b1;         // held through the done cycle too
        write_data_array = mem_valid;    // every returned word
        write_tag_array  = done;         // line complete, mark valid
        if (done)
          nxt_state = fill_idle;
      end
      default: begin
        nxt_state = fill_idle;           // recover to idle
      end
    endcase
  end

  // block base of the missing line plus the word being fetched
  // counter sits at 0 while idle so the first request is word 0
  assign mem_addr = {get_tag(miss_addr), get_index(miss_addr), cnt, 1'b0};

endmodule

//--- cache/cache_tag_array.sv
`timescale 1ns/100ps
module cache_tag_array import cache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  rd,               // processor read level
  input  logic  stall,            // fill in progress
  input  logic  write_tag_array,  // from the fill fsm, last word of a line
  input  addr_t addr,             // processor address, steady during stall
  output logic  hit,
  output logic  miss_detected
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////
  tag_t                tags [NUM_SETS];   // no reset, guarded by valid
  logic [NUM_SETS-1:0] valid;             // cleared on reset

  index_t idx;
  tag_t   req_tag;

  assign idx     = get_index(addr);
  assign req_tag = get_tag(addr);

  // valid bits
  always_ff @(posedge clk) begin
    if (rst)
      valid <= '0;                        // every set empty
    else if (write_tag_array)
      valid[idx] <= 1'b1;
  end

  // tag store, written alongside the valid bit
  always_ff @(posedge clk) begin
    if (write_tag_array)
      tags[idx] <= req_tag;
  end

  //////////////////////////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////////////////////////
  assign hit = valid[idx] && (tags[idx] == req_tag);

  // the only place a miss is decided, the fsm takes it as is
  assign miss_detected = rd && !stall && !hit;

endmodule

//--- common/cache_pkg.sv
package cache_pkg;

  //////////////////////////////////////////////////////////////////////
  // address layout: tag[15:8] index[7:4] offset[3:1], bit 0 ignored
  //////////////////////////////////////////////////////////////////////
  localparam int ADDR_W      = 16;
  localparam int WORD_W      = 16;
  localparam int OFFSET_W    = 3;                          // 8 words per line
  localparam int INDEX_W     = 4;                          // 16 sets
  localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W - 1;
  localparam int OFFSET_LSB  = 1;                          // byte bit skipped
  localparam int INDEX_LSB   = OFFSET_LSB + OFFSET_W;
  localparam int TAG_LSB     = INDEX_LSB + INDEX_W;

  localparam int NUM_SETS    = 1 << INDEX_W;
  localparam int BLOCK_WORDS = 1 << OFFSET_W;
  localparam int DATA_WORDS  = NUM_SETS * BLOCK_WORDS;     // whole data array

  // main memory timing, cycles from accept to valid pulse
  localparam int MEM_LATENCY = 4;
  localparam int LAT_W       = $clog2(MEM_LATENCY + 1);

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;   // also the fill word counter
  typedef logic [LAT_W-1:0]    lat_cnt_t;

  // rom rule: word at byte addr a is (a >> 1) ^ MEM_KEY
  localparam word_t MEM_KEY = 16'h3c5a;

  typedef enum logic {
    fill_idle,   // waiting for a miss
    fill_wait    // words in flight from memory
  } fill_state_t;

  // field extraction
  function automatic tag_t get_tag(input addr_t a);
    return a[TAG_LSB +: TAG_W];
  endfunction

  function automatic index_t get_index(input addr_t a);
    return a[INDEX_LSB +: INDEX_W];
  endfunction

  function automatic offset_t get_offset(input addr_t a);
    return a[OFFSET_LSB +: OFFSET_W];
  endfunction

endpackage

//--- hdl/main_memory.sv
`timescale 1ns/100ps
module main_memory import cache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  mem_read,    // request level, held by the fill fsm
  input  addr_t mem_addr,    // sampled when a request is accepted
  output logic  mem_valid,   // single cycle, MEM_LATENCY after accept
  output word_t mem_data     // rom word for the accepted address
);

  // rom content rule, word address xor key
  function automatic word_t rom_word(input addr_t a);
    return word_t'(a >> 1) ^ MEM_KEY;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // request tracking, one word in flight
  //////////////////////////////////////////////////////////////////////
  logic     pending;     // a word is in flight
  lat_cnt_t countdown;   // cycles left until the valid pulse
  addr_t    req_addr;    // address of the word in flight
  logic     accept;

  assign accept = mem_read && !pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending   <= 1'b0;
      countdown <= '0;
    end else if (accept) begin
      pending   <= 1'b1;
      countdown <= lat_cnt_t'(MEM_LATENCY);
    end else if (mem_valid) begin
      pending   <= 1'b0;        // idle again next cycle
    end else if (pending) begin
      countdown <= countdown - 1'b1;
    end
  end

  // address latch, payload only
  always_ff @(posedge clk) begin
    if (accept)
      req_addr <= mem_addr;
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////
  // accept in cycle n loads the countdown, it reads 1 in cycle n+MEM_LATENCY
  assign mem_valid = pending && (countdown == lat_cnt_t'(1));

  // data only meaningful with the pulse, zero otherwise
  assign mem_data = mem_valid ? rom_word(req_addr) : '0;

endmodule

//--- hdl/mem_system.sv
`timescale 1ns/100ps
module mem_system import cache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  rd,        // processor read level
  input  addr_t addr,      // processor byte address
  output word_t rd_data,   // valid with hit and no stall
  output logic  hit,
  output logic  stall      // line fill in progress, cpu holds rd and addr
);

  //////////////////////////////////////////////////////////////////////
  // internal nets
  //////////////////////////////////////////////////////////////////////
  logic  miss_detected;     // tag array -> fill fsm
  logic  write_data_array;  // fill fsm -> data array
  logic  write_tag_array;   // fill fsm -> tag array
  logic  mem_valid;         // memory -> fsm and data array
  addr_t mem_addr;          // fsm -> memory, also the fill write address
  word_t mem_data;          // memory -> data array

  //////////////////////////////////////////////////////////////////////
  // cache arrays
  //////////////////////////////////////////////////////////////////////
  cache_tag_array tag_array_inst (
    .clk             (clk),
    .rst             (rst),
    .rd              (rd),
    .stall           (stall),
    .write_tag_array (write_tag_array),
    .addr            (addr),
    .hit             (hit),
    .miss_detected   (miss_detected)
  );

  cache_data_array data_array_inst (
    .clk              (clk),
    .write_data_array (write_data_array),
    .addr             (addr),
    .fill_addr        (mem_addr),      // index and offset of the word arriving
    .fill_data        (mem_data),
    .rd_data          (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // miss handling and backing store
  //////////////////////////////////////////////////////////////////////
  cache_fill_fsm fill_fsm_inst (
    .clk              (clk),
    .rst              (rst),
    .miss_detected    (miss_detected),
    .mem_valid        (mem_valid),
    .miss_addr        (addr),          // cpu address held during the stall
    .busy             (stall),         // busy is both stall and mem_read
    .write_data_array (write_data_array),
    .write_tag_array  (write_tag_array),
    .mem_addr         (mem_addr)
  );

  main_memory main_memory_inst (
    .clk       (clk),
    .rst       (rst),
    .mem_read  (stall),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid),
    .mem_data  (mem_data)
  );

endmodule

//--- vlog.f
common/cache_pkg.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_fill_fsm.sv
hdl/main_memory.sv
hdl/mem_system.sv
bench/mem_system_props.sv
bench/mem_system_tb.sv
